/* rmt_pkt_pkg.sv */
package rmt_pkt_pkg;

	// header field and vlan widths
	localparam int field_w = 24;
	localparam int vlan_w = 12;

	// bits carried in the header vector once the type bit is stripped
	localparam int body_w = 63;

	// data packet header, top bit low
	typedef struct packed {
		logic is_ctrl;
		logic [2:0] spare;
		logic [vlan_w-1:0] vlan;
		logic [field_w-1:0] field_a;
		logic [field_w-1:0] field_b;
	} data_hdr_t;

	// in-band control message, top bit high
	typedef struct packed {
		logic is_ctrl;
		logic [3:0] stage_sel;
		logic [1:0] op;
		// 0 picks field_a
		logic field_sel;
		logic [31:0] pad;
		logic [field_w-1:0] operand;
	} ctrl_msg_t;

	// one 64-bit beat, decoded by its top bit
	typedef union packed {
		data_hdr_t data;
		ctrl_msg_t ctrl;
	} pkt_beat_u;

	// header vector handed down the pipe
	typedef struct packed {
		logic valid;
		logic is_ctrl;
		logic [body_w-1:0] body;
	} phv_t;

	// put the type bit back on top of the carried bits
	function automatic pkt_beat_u to_beat(phv_t phv);
		pkt_beat_u beat;
		beat = {phv.is_ctrl, phv.body};
		return beat;
	endfunction

endpackage

/* rmt_cfg_pkg.sv */
package rmt_cfg_pkg;

	// default pipeline shape
	localparam int num_stages_def = 4;
	localparam int fifo_depth_bits_def = 4;

	// stage action opcodes, same encoding as the control message op field
	typedef enum logic [1:0] {
		op_nop = 2'd0,
		op_set = 2'd1,
		op_add = 2'd2,
		op_sub = 2'd3
	} action_op_e;

	// programmable action of one stage
	typedef struct packed {
		action_op_e op;
		// 0 picks field_a
		logic field_sel;
		logic [rmt_pkt_pkg::field_w-1:0] operand;
	} action_t;

endpackage

/* pkt_filter.sv */
`timescale 1ns/100ps

module pkt_filter (
	input logic clk,
	input logic aresetn,
	input logic [31:0] vlan_drop_flags,
	input rmt_pkt_pkg::pkt_beat_u s_beat,
	input logic s_valid,
	output logic s_ready,
	input logic fifo_nearly_full,
	output rmt_pkt_pkg::phv_t phv_out,
	output logic [31:0] ctrl_token
);

	logic accept;
	logic beat_is_ctrl;
	logic vlan_masked;

	// throttle input while the fifo has no room for the in-flight vectors
	assign s_ready = ~fifo_nearly_full;
	assign accept = s_valid & s_ready;

	// type comes from the shared top bit
	assign beat_is_ctrl = s_beat.data.is_ctrl;

	// mask indexed by low five bits of the vlan id
	assign vlan_masked = vlan_drop_flags[s_beat.data.vlan[4:0]];

	// header vector register, one cycle after accept
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			phv_out.valid <= 1'b0;
		end else begin
			// masked data beats are consumed but leave no valid vector
			phv_out.valid <= accept & (beat_is_ctrl | ~vlan_masked);
			phv_out.is_ctrl <= beat_is_ctrl;
			// raw bits below the type bit, either view
			phv_out.body <= s_beat[rmt_pkt_pkg::body_w-1:0];
		end
	end

	// count of accepted control messages
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			ctrl_token <= '0;
		end else if (accept && beat_is_ctrl) begin
			ctrl_token <= ctrl_token + 32'd1;
		end
	end

endmodule

/* action_stage.sv */
`timescale 1ns/100ps

module action_stage #(
	parameter int stage_id = 0
) (
	input logic clk,
	input logic aresetn,
	input rmt_pkt_pkg::phv_t phv_in,
	output rmt_pkt_pkg::phv_t phv_out
);

	rmt_cfg_pkg::action_t act_q;
	rmt_pkt_pkg::pkt_beat_u beat;
	rmt_pkt_pkg::pkt_beat_u nxt_beat;
	rmt_pkt_pkg::phv_t phv_nxt;
	logic [rmt_pkt_pkg::field_w-1:0] fld;
	logic [rmt_pkt_pkg::field_w-1:0] res;
	logic hit;

	assign beat = rmt_pkt_pkg::to_beat(phv_in);

	// control message aimed at this stage
	assign hit = phv_in.valid & phv_in.is_ctrl & (beat.ctrl.stage_sel == 4'(stage_id));

	// action register, loaded in band
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			act_q.op <= rmt_cfg_pkg::op_nop;
			act_q.field_sel <= 1'b0;
			act_q.operand <= '0;
		end else if (hit) begin
			act_q.op <= rmt_cfg_pkg::action_op_e'(beat.ctrl.op);
			act_q.field_sel <= beat.ctrl.field_sel;
			act_q.operand <= beat.ctrl.operand;
		end
	end

	always_comb begin
		fld = act_q.field_sel ? beat.data.field_b : beat.data.field_a;
		// wraps mod 2^24 by width
		case (act_q.op)
			rmt_cfg_pkg::op_set: res = act_q.operand;
			rmt_cfg_pkg::op_add: res = fld + act_q.operand;
			rmt_cfg_pkg::op_sub: res = fld - act_q.operand;
			default: res = fld;
		endcase
		nxt_beat = beat;
		if (act_q.field_sel) begin
			nxt_beat.data.field_b = res;
		end else begin
			nxt_beat.data.field_a = res;
		end
		// control vectors pass through untouched
		phv_nxt = phv_in;
		if (!phv_in.is_ctrl) begin
			phv_nxt.body = nxt_beat[rmt_pkt_pkg::body_w-1:0];
		end
	end

	// fixed one-cycle hop
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			phv_out.valid <= 1'b0;
		end else begin
			phv_out <= phv_nxt;
		end
	end

endmodule

/* phv_fifo.sv */
`timescale 1ns/100ps

module phv_fifo #(
	parameter int fifo_depth_bits = 4,
	parameter int num_stages = 4
) (
	input logic clk,
	input logic aresetn,
	input rmt_pkt_pkg::phv_t wr_phv,
	input logic rd_en,
	output rmt_pkt_pkg::phv_t rd_phv,
	output logic empty,
	output logic nearly_full
);

	localparam int depth = 1 << fifo_depth_bits;
	// filter register, every stage register, and the beat accepted this cycle
	localparam int margin = num_stages + 2;
	localparam logic [fifo_depth_bits:0] thresh = (fifo_depth_bits+1)'(depth - margin);

	rmt_pkt_pkg::phv_t mem [0:depth-1];
	logic [fifo_depth_bits-1:0] wr_ptr;
	logic [fifo_depth_bits-1:0] rd_ptr;
	logic [fifo_depth_bits:0] count;
	logic wr;
	logic rd;

	// only valid data vectors are queued
	assign wr = wr_phv.valid & ~wr_phv.is_ctrl;
	assign rd = rd_en & ~empty;

	// fall-through head
	assign rd_phv = mem[rd_ptr];
	assign empty = (count == '0);
	// free entries at or below margin
	assign nearly_full = (count >= thresh);

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[wr_ptr] <= wr_phv;
		end
	end

	// pointers wrap at depth
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr, rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

endmodule

/* deparser.sv */
`timescale 1ns/100ps

module deparser (
	input logic clk,
	input logic aresetn,
	input rmt_pkt_pkg::phv_t fifo_phv,
	input logic fifo_empty,
	output logic rd_en,
	output rmt_pkt_pkg::pkt_beat_u m_beat,
	output logic m_valid,
	input logic m_ready
);

	logic load;

	// refill when the slot is free or drains this cycle
	assign load = ~fifo_empty & (~m_valid | m_ready);
	assign rd_en = load;

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			m_valid <= 1'b0;
		end else if (load) begin
			m_valid <= 1'b1;
		end else if (m_ready) begin
			m_valid <= 1'b0;
		end
	end

	// output beat held under back-pressure
	always_ff @(posedge clk) begin
		if (load) begin
			// top bit rebuilt, low for data
			m_beat <= rmt_pkt_pkg::to_beat(fifo_phv);
		end
	end

endmodule

/* rmt_top.sv */
`timescale 1ns/100ps

module rmt_top #(
	parameter int num_stages = rmt_cfg_pkg::num_stages_def,
	parameter int fifo_depth_bits = rmt_cfg_pkg::fifo_depth_bits_def
) (
	input logic clk,
	input logic aresetn,
	input logic [31:0] vlan_drop_flags,
	input rmt_pkt_pkg::pkt_beat_u s_beat,
	input logic s_valid,
	output logic s_ready,
	output logic [31:0] ctrl_token,
	output rmt_pkt_pkg::pkt_beat_u m_beat,
	output logic m_valid,
	input logic m_ready
);

	// stg_phv[0] from filter, stg_phv[num_stages] into the fifo
	rmt_pkt_pkg::phv_t stg_phv [0:num_stages];
	rmt_pkt_pkg::phv_t fifo_head;
	logic fifo_empty;
	logic fifo_rd_en;
	logic fifo_nearly_full;

	pkt_filter i_filter (
		.clk(clk),
		.aresetn(aresetn),
		.vlan_drop_flags(vlan_drop_flags),
		.s_beat(s_beat),
		.s_valid(s_valid),
		.s_ready(s_ready),
		.fifo_nearly_full(fifo_nearly_full),
		.phv_out(stg_phv[0]),
		.ctrl_token(ctrl_token)
	);

	// stage chain, one register per hop
	for (genvar i = 0; i < num_stages; i++) begin : g_stage
		action_stage #(.stage_id(i)) i_stage (
			.clk(clk),
			.aresetn(aresetn),
			.phv_in(stg_phv[i]),
			.phv_out(stg_phv[i+1])
		);
	end

	phv_fifo #(.fifo_depth_bits(fifo_depth_bits), .num_stages(num_stages)) i_fifo (
		.clk(clk),
		.aresetn(aresetn),
		.wr_phv(stg_phv[num_stages]),
		.rd_en(fifo_rd_en),
		.rd_phv(fifo_head),
		.empty(fifo_empty),
		.nearly_full(fifo_nearly_full)
	);

	deparser i_deparser (
		.clk(clk),
		.aresetn(aresetn),
		.fifo_phv(fifo_head),
		.fifo_empty(fifo_empty),
		.rd_en(fifo_rd_en),
		.m_beat(m_beat),
		.m_valid(m_valid),
		.m_ready(m_ready)
	);

endmodule

/* rmt_properties.sv */
`timescale 1ns/100ps

module rmt_properties (
	input logic clk,
	input logic aresetn,
	input rmt_pkt_pkg::pkt_beat_u m_beat,
	input logic m_valid,
	input logic m_ready,
	input logic s_ready
);

	// output beat held while the sink stalls
	a_out_hold: assert property (@(posedge clk) disable iff (!aresetn)
		m_valid && !m_ready |=> m_valid && $stable(m_beat))
		else $error("m_beat or m_valid changed under back-pressure");

	// input open right after reset
	a_ready_after_reset: assert property (@(posedge clk)
		$rose(aresetn) |-> s_ready)
		else $error("s_ready low in first cycle after reset");

	// no output while in reset
	a_quiet_in_reset: assert property (@(posedge clk)
		!aresetn |=> !m_valid)
		else $error("m_valid high during reset");

endmodule

bind rmt_top rmt_properties i_props (
	.clk(clk),
	.aresetn(aresetn),
	.m_beat(m_beat),
	.m_valid(m_valid),
	.m_ready(m_ready),
	.s_ready(s_ready)
);

/* tb_rmt.sv */
`timescale 1ns/100ps

module tb_rmt;

	localparam int n_stages = 4;
	localparam int n_depth_bits = 4;

	// beats sent per phase, used to size the watchdog
	localparam int p1_beats = 20;
	localparam int p2_beats = 4 + 20 + 4 + 10;
	localparam int p3_beats = 4 * 3;
	localparam int p4_beats = 30;
	localparam int p5_beats = 6 * 11;
	localparam int total_pkts = p1_beats + p2_beats + p3_beats + p4_beats + p5_beats;

	logic clk;
	logic aresetn;
	logic [31:0] vlan_drop_flags;
	rmt_pkt_pkg::pkt_beat_u s_beat;
	logic s_valid;
	logic s_ready;
	logic [31:0] ctrl_token;
	rmt_pkt_pkg::pkt_beat_u m_beat;
	logic m_valid;
	logic m_ready;

	// model state, updated in send order
	rmt_cfg_pkg::action_t [n_stages-1:0] model_acts;
	logic [31:0] model_mask;
	int ctrl_sent;
	logic [63:0] exp_q [$];

	int mismatch_errs;
	int other_errs;
	// 0 always ready, 1 random
	int ready_mode;
	logic saw_stall;

	rmt_top #(
		.num_stages(n_stages),
		.fifo_depth_bits(n_depth_bits)
	) i_dut (
		.clk(clk),
		.aresetn(aresetn),
		.vlan_drop_flags(vlan_drop_flags),
		.s_beat(s_beat),
		.s_valid(s_valid),
		.s_ready(s_ready),
		.ctrl_token(ctrl_token),
		.m_beat(m_beat),
		.m_valid(m_valid),
		.m_ready(m_ready)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	// expected output: every stage action applied in pipeline order, mod 2^24
	function automatic logic [63:0] model_beat(rmt_pkt_pkg::pkt_beat_u in,
			rmt_cfg_pkg::action_t [n_stages-1:0] acts);
		rmt_pkt_pkg::pkt_beat_u b;
		logic [23:0] f;
		logic [23:0] r;
		int i;
		b = in;
		for (i = 0; i < n_stages; i++) begin
			f = acts[i].field_sel ? b.data.field_b : b.data.field_a;
			case (acts[i].op)
				rmt_cfg_pkg::op_set: r = acts[i].operand;
				rmt_cfg_pkg::op_add: r = f + acts[i].operand;
				rmt_cfg_pkg::op_sub: r = f - acts[i].operand;
				default: r = f;
			endcase
			if (acts[i].field_sel) begin
				b.data.field_b = r;
			end else begin
				b.data.field_a = r;
			end
		end
		return b;
	endfunction

	function automatic rmt_pkt_pkg::pkt_beat_u rand_data(logic [11:0] vlan);
		rmt_pkt_pkg::pkt_beat_u b;
		b.data.is_ctrl = 1'b0;
		b.data.spare = 3'($urandom);
		b.data.vlan = vlan;
		b.data.field_a = 24'($urandom);
		b.data.field_b = 24'($urandom);
		return b;
	endfunction

	function automatic rmt_pkt_pkg::pkt_beat_u make_ctrl(logic [3:0] stage, logic [1:0] op,
			logic sel, logic [23:0] operand);
		rmt_pkt_pkg::pkt_beat_u b;
		b.ctrl.is_ctrl = 1'b1;
		b.ctrl.stage_sel = stage;
		b.ctrl.op = op;
		b.ctrl.field_sel = sel;
		b.ctrl.pad = 32'($urandom);
		b.ctrl.operand = operand;
		return b;
	endfunction

	task automatic check_value(input string what, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			mismatch_errs++;
			$display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// hold the beat until s_ready is seen, then update the model
	task automatic send_beat(input rmt_pkt_pkg::pkt_beat_u b);
		s_beat = b;
		s_valid = 1'b1;
		@(negedge clk);
		while (!s_ready) begin
			@(negedge clk);
		end
		if (b.ctrl.is_ctrl) begin
			ctrl_sent++;
			if (int'(b.ctrl.stage_sel) < n_stages) begin
				model_acts[b.ctrl.stage_sel].op = rmt_cfg_pkg::action_op_e'(b.ctrl.op);
				model_acts[b.ctrl.stage_sel].field_sel = b.ctrl.field_sel;
				model_acts[b.ctrl.stage_sel].operand = b.ctrl.operand;
			end
		end else if (!model_mask[b.data.vlan[4:0]]) begin
			exp_q.push_back(model_beat(b, model_acts));
		end
		@(posedge clk);
		#2;
		s_valid = 1'b0;
	endtask

	task automatic send_random(input int n);
		repeat (n) begin
			send_beat(rand_data(12'($urandom)));
		end
	endtask

	task automatic set_mask(input logic [31:0] mask);
		vlan_drop_flags = mask;
		model_mask = mask;
	endtask

	// wait until every expected beat has left the DUT
	task automatic drain;
		@(negedge clk);
		while (exp_q.size() != 0 || m_valid) begin
			@(negedge clk);
		end
		// back to the drive point just after the rising edge
		@(posedge clk);
		#2;
	endtask

	// sink ready, changed just after the edge
	initial begin
		forever begin
			@(posedge clk);
			#2;
			if (ready_mode == 1) begin
				m_ready = ($urandom % 3 == 0);
			end else begin
				m_ready = 1'b1;
			end
		end
	end

	// compare on each output transfer, sampled mid-cycle
	initial begin
		forever begin
			@(negedge clk);
			if (aresetn && !s_ready) begin
				saw_stall = 1'b1;
			end
			if (aresetn && m_valid && m_ready) begin
				if (exp_q.size() == 0) begin
					other_errs++;
					$display("unexpected output beat %h at %0t", m_beat, $time);
				end else begin
					check_value("output beat", m_beat, exp_q.pop_front());
				end
			end
		end
	end

	initial begin
		repeat (total_pkts * 40 + 200) @(posedge clk);
		$display("timeout: the pipeline did not deliver every beat in time");
		$display("tests failed");
		$finish;
	end

	initial begin
		void'($urandom(32'hb844));
		aresetn = 1'b0;
		s_valid = 1'b0;
		s_beat = '0;
		vlan_drop_flags = '0;
		m_ready = 1'b0;
		model_acts = '0;
		model_mask = '0;
		ctrl_sent = 0;
		mismatch_errs = 0;
		other_errs = 0;
		ready_mode = 0;
		saw_stall = 1'b0;
		repeat (5) @(posedge clk);
		#2;
		aresetn = 1'b1;

		// all nop, beats pass unchanged
		send_random(p1_beats);
		drain();
		check_value("ctrl_token after reset", 64'(ctrl_token), 64'd0);

		// program every stage, then reprogram
		send_beat(make_ctrl(4'd0, 2'd2, 1'b0, 24'h800001));
		send_beat(make_ctrl(4'd1, 2'd3, 1'b1, 24'h123456));
		send_beat(make_ctrl(4'd2, 2'd1, 1'b1, 24'habcdef));
		send_beat(make_ctrl(4'd3, 2'd2, 1'b1, 24'hfffff0));
		send_random(20);
		send_beat(make_ctrl(4'd0, 2'd3, 1'b0, 24'hfedcba));
		send_beat(make_ctrl(4'd1, 2'd1, 1'b0, 24'h000042));
		send_beat(make_ctrl(4'd2, 2'd2, 1'b0, 24'hffffff));
		send_beat(make_ctrl(4'd3, 2'd0, 1'b0, 24'h000000));
		send_random(10);
		drain();

		// control between two data beats
		for (int k = 0; k < 4; k++) begin
			send_beat(rand_data(12'($urandom)));
			send_beat(make_ctrl(4'(k), 2'd2, 1'b1, 24'($urandom)));
			send_beat(rand_data(12'($urandom)));
		end
		drain();

		// per-vlan drop
		set_mask(32'h5a5a_c3c3);
		send_random(p4_beats);
		set_mask(32'h0);
		drain();

		// random back-pressure, input should stall
		ready_mode = 1;
		repeat (6) begin
			send_beat(make_ctrl(4'($urandom % 4), 2'($urandom), 1'($urandom), 24'($urandom)));
			send_random(10);
		end
		drain();
		ready_mode = 0;
		if (!saw_stall) begin
			other_errs++;
			$display("s_ready never fell while the sink was throttled");
		end

		check_value("ctrl_token", 64'(ctrl_token), 64'(ctrl_sent));

		$display("errors: %0d mismatches, %0d other", mismatch_errs, other_errs);
		if (mismatch_errs == 0 && other_errs == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* build.f */
rmt_pkt_pkg.sv
rmt_cfg_pkg.sv
pkt_filter.sv
action_stage.sv
phv_fifo.sv
deparser.sv
rmt_top.sv
rmt_properties.sv
tb_rmt.sv

/* run.sh */
#!/bin/sh
# compile with Verilator and run; pass only if the pass line is printed
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_rmt -o tb_rmt \
	&& ./obj_dir/tb_rmt | tee /dev/stderr | grep -q "^all tests passed$" \
	&& echo "simulation ok" \
	|| { echo "simulation failed"; exit 1; }
